// ==== verilog/fp_mult_pkg.sv ====
// shared FSM state type and default parameter values, referenced by scoped name in the multiplier
package fp_mult_pkg;

  // ========================================
  // control FSM states
  // ========================================

  // idle   waiting for an operand pair
  // calc   one shift-add step per cycle, WIDTH cycles
  // done   result held until the result queue takes it
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } mult_state_e;

  // ========================================
  // default configuration
  // ========================================

  // operand and result width in bits
  localparam int DEF_WIDTH = 16;

  // fraction bits of the fixed-point format
  // result is product bits FRAC .. WIDTH+FRAC-1
  localparam int DEF_FRAC = 8;

  // two's-complement operands when set
  // unsigned operands, no final correction, when clear
  localparam bit DEF_SIGNED = 1'b1;

  // entries in each of the request and result queues
  localparam int DEF_FIFO_DEPTH = 2;

endpackage

// ==== verilog/stream_fifo.sv ====
// valid/ready queue with a configurable payload type, used for both requests and results
`timescale 1ns/1ps

module stream_fifo #(
  parameter int DEPTH = fp_mult_pkg::DEF_FIFO_DEPTH,
  parameter type payload_t = logic [fp_mult_pkg::DEF_WIDTH-1:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // circular pointer advance
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // full and empty come straight from the occupancy count
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // head entry, read from the storage registers
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= bump(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= bump(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // occupancy never passes the depth
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH));

  // an empty queue only fills through a push, so the count never wraps below zero
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    (count == '0) && !push |=> count == '0);

endmodule

// ==== verilog/fp_mult_ctrl.sv ====
// control FSM and step counter that sequence one multiplication and run both stream handshakes
`timescale 1ns/1ps

module fp_mult_ctrl #(
  parameter int WIDTH = fp_mult_pkg::DEF_WIDTH
) (
  input  logic clk,
  input  logic reset,
  input  logic op_valid,
  output logic op_ready,
  output logic res_valid,
  input  logic res_ready,
  output logic load,
  output logic step,
  output logic last_step
);

  localparam int CNT_W = $clog2(WIDTH);

  fp_mult_pkg::mult_state_e state;
  fp_mult_pkg::mult_state_e state_next;
  logic [CNT_W-1:0]         cnt;
  logic                     cnt_last;

  assign cnt_last = (cnt == CNT_W'(WIDTH - 1));

  // ========================================
  // handshake and datapath controls
  // ========================================

  assign op_ready  = (state == fp_mult_pkg::idle);
  assign res_valid = (state == fp_mult_pkg::done);
  assign step      = (state == fp_mult_pkg::calc);
  assign last_step = step && cnt_last;

  // operands captured in the cycle of acceptance
  assign load = op_ready && op_valid;

  // ========================================
  // next state
  // ========================================

  always_comb begin
    state_next = state;
    case (state)
      fp_mult_pkg::idle: begin
        if (op_valid) begin
          state_next = fp_mult_pkg::calc;
        end
      end
      fp_mult_pkg::calc: begin
        if (cnt_last) begin
          state_next = fp_mult_pkg::done;
        end
      end
      fp_mult_pkg::done: begin
        // wait here while the result queue is full
        if (res_ready) begin
          state_next = fp_mult_pkg::idle;
        end
      end
      default: state_next = fp_mult_pkg::idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fp_mult_pkg::idle;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (state == fp_mult_pkg::calc) begin
        cnt <= cnt + 1'b1;
      end else if (state == fp_mult_pkg::done) begin
        cnt <= '0;
      end
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {fp_mult_pkg::idle, fp_mult_pkg::calc, fp_mult_pkg::done});

  // result offer is held until the result queue accepts it
  a_res_hold: assert property (@(posedge clk) disable iff (reset)
    res_valid && !res_ready |=> res_valid);

endmodule

// ==== verilog/fp_mult_dpath.sv ====
// shift-add datapath with operand registers, accumulator and two's-complement final correction
`timescale 1ns/1ps

module fp_mult_dpath #(
  parameter int WIDTH  = fp_mult_pkg::DEF_WIDTH,
  parameter int FRAC   = fp_mult_pkg::DEF_FRAC,
  parameter bit SIGNED = fp_mult_pkg::DEF_SIGNED
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic             step,
  input  logic             last_step,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] c
);

  // only the low WIDTH+FRAC product bits reach the result
  localparam int EW = WIDTH + FRAC;

  logic [EW-1:0]    a_ext;
  logic [EW-1:0]    a_keep;
  logic [EW-1:0]    a_sh;
  logic [WIDTH-1:0] b_sh;
  logic [EW-1:0]    acc;
  logic [EW-1:0]    corr;
  logic [EW-1:0]    term;

  // ========================================
  // operand extension and step term
  // ========================================

  always_comb begin
    if (SIGNED) begin
      a_ext = EW'($signed(a));
    end else begin
      a_ext = EW'(a);
    end
  end

  // weight of b's top bit is -2^(WIDTH-1) in two's complement
  assign corr = a_keep << (WIDTH - 1);

  always_comb begin
    if (SIGNED && last_step) begin
      term = -corr;
    end else begin
      term = a_sh;
    end
  end

  // ========================================
  // operand shift registers and accumulator
  // ========================================

  always_ff @(posedge clk) begin
    if (load) begin
      a_keep <= a_ext;
      a_sh   <= a_ext;
      b_sh   <= b;
    end else if (step) begin
      a_sh <= a_sh << 1;
      b_sh <= b_sh >> 1;
    end
  end

  // accumulator cleared on each operand load
  always_ff @(posedge clk) begin
    if (reset || load) begin
      acc <= '0;
    end else if (step && b_sh[0]) begin
      acc <= acc + term;
    end
  end

  // product shifted right by FRAC and wrapped to WIDTH bits
  assign c = acc[EW-1:FRAC];

endmodule

// ==== verilog/fp_mult_unit.sv ====
// top level of the iterative fixed-point multiplier with request and result stream queues
`timescale 1ns/1ps

module fp_mult_unit #(
  parameter int WIDTH      = fp_mult_pkg::DEF_WIDTH,
  parameter int FRAC       = fp_mult_pkg::DEF_FRAC,
  parameter bit SIGNED     = fp_mult_pkg::DEF_SIGNED,
  parameter int FIFO_DEPTH = fp_mult_pkg::DEF_FIFO_DEPTH
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_valid,
  output logic             req_ready,
  input  logic [WIDTH-1:0] req_a,
  input  logic [WIDTH-1:0] req_b,
  output logic             resp_valid,
  input  logic             resp_ready,
  output logic [WIDTH-1:0] resp_c
);

  // ========================================
  // internal streams
  // ========================================

  // request queue head, a in the upper half
  logic               op_valid;
  logic               op_ready;
  logic [2*WIDTH-1:0] op_data;

  // finished product toward the result queue
  logic               res_valid;
  logic               res_ready;
  logic [WIDTH-1:0]   res_data;

  // sequencing from control to datapath
  logic               load;
  logic               step;
  logic               last_step;

  stream_fifo #(
    .DEPTH    (FIFO_DEPTH),
    .payload_t(logic [2*WIDTH-1:0])
  ) req_q (
    .clk      (clk),
    .reset    (reset),
    .in_valid (req_valid),
    .in_ready (req_ready),
    .in_data  ({req_a, req_b}),
    .out_valid(op_valid),
    .out_ready(op_ready),
    .out_data (op_data)
  );

  fp_mult_ctrl #(
    .WIDTH(WIDTH)
  ) ctrl (
    .clk      (clk),
    .reset    (reset),
    .op_valid (op_valid),
    .op_ready (op_ready),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .load     (load),
    .step     (step),
    .last_step(last_step)
  );

  fp_mult_dpath #(
    .WIDTH (WIDTH),
    .FRAC  (FRAC),
    .SIGNED(SIGNED)
  ) dpath (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .last_step(last_step),
    .a        (op_data[2*WIDTH-1:WIDTH]),
    .b        (op_data[WIDTH-1:0]),
    .c        (res_data)
  );

  stream_fifo #(
    .DEPTH    (FIFO_DEPTH),
    .payload_t(logic [WIDTH-1:0])
  ) resp_q (
    .clk      (clk),
    .reset    (reset),
    .in_valid (res_valid),
    .in_ready (res_ready),
    .in_data  (res_data),
    .out_valid(resp_valid),
    .out_ready(resp_ready),
    .out_data (resp_c)
  );

endmodule

// ==== dv/fp_mult_checker.sv ====
// testbench checker that watches the multiplier ports, models each product and compares in order
`timescale 1ns/1ps

module fp_mult_checker #(
  parameter int WIDTH  = fp_mult_pkg::DEF_WIDTH,
  parameter int FRAC   = fp_mult_pkg::DEF_FRAC,
  parameter bit SIGNED = fp_mult_pkg::DEF_SIGNED
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_valid,
  input  logic             req_ready,
  input  logic [WIDTH-1:0] req_a,
  input  logic [WIDTH-1:0] req_b,
  input  logic             resp_valid,
  input  logic             resp_ready,
  input  logic [WIDTH-1:0] resp_c,
  output int               req_count,
  output int               resp_count,
  output int               err_count
);

  // expected results and acceptance cycles in request order
  logic [WIDTH-1:0] exp_q[$];
  int               when_q[$];
  int               cycle = 0;
  int               reqs = 0;
  int               resps = 0;
  int               errs = 0;
  logic             was_reset = 1'b0;
  logic             held = 1'b0;
  logic [WIDTH-1:0] held_c = '0;

  assign req_count  = reqs;
  assign resp_count = resps;
  assign err_count  = errs;

  // full product of the extended operands and its bits from FRAC upward
  function automatic logic [WIDTH-1:0] model_product(input logic [WIDTH-1:0] a,
                                                     input logic [WIDTH-1:0] b);
    logic [2*WIDTH-1:0] ea;
    logic [2*WIDTH-1:0] eb;
    logic [2*WIDTH-1:0] full;
    ea   = {{WIDTH{SIGNED & a[WIDTH-1]}}, a};
    eb   = {{WIDTH{SIGNED & b[WIDTH-1]}}, b};
    full = ea * eb;
    return full[FRAC +: WIDTH];
  endfunction

  always @(posedge clk) begin : watch
    logic [WIDTH-1:0] exp_c;
    int               lat;
    int               taken_at;
    cycle++;
    // first edge after reset release shows the reset values
    if (was_reset && !reset) begin
      if (resp_valid !== 1'b0) begin
        $display("[ERROR] resp_valid after reset expected 0 got %h", resp_valid);
        errs++;
      end
      if (req_ready !== 1'b1) begin
        $display("[ERROR] req_ready after reset expected 1 got %h", req_ready);
        errs++;
      end
    end
    was_reset = reset;
    if (reset) begin
      held = 1'b0;
    end else begin
      // an offer not yet taken keeps its data
      if (held && resp_valid !== 1'b1) begin
        $display("resp_valid dropped before the result was taken");
        errs++;
      end else if (held && resp_c !== held_c) begin
        $display("[ERROR] resp_c changed while held, expected %h got %h", held_c, resp_c);
        errs++;
      end
      // first cycle of a new offer
      if (resp_valid && !held) begin
        if (when_q.size() == 0) begin
          $display("response offered with no request pending");
          errs++;
        end else begin
          lat = cycle - when_q[0];
          if (lat < WIDTH + 3) begin
            $display("response after %0d cycles, minimum is %0d", lat, WIDTH + 3);
            errs++;
          end
        end
      end
      if (resp_valid && resp_ready && exp_q.size() != 0) begin
        exp_c    = exp_q.pop_front();
        taken_at = when_q.pop_front();
        resps++;
        if (resp_c !== exp_c) begin
          $display("[ERROR] resp_c expected %h got %h (request %0d, accepted at cycle %0d)",
                   exp_c, resp_c, resps, taken_at);
          errs++;
        end
      end
      if (req_valid && req_ready) begin
        exp_q.push_back(model_product(req_a, req_b));
        when_q.push_back(cycle);
        reqs++;
      end
      held   = resp_valid && !resp_ready;
      held_c = resp_c;
    end
  end

endmodule

// ==== dv/fp_mult_tb.sv ====
// testbench top with clock, reset, seeded random requests and back-pressure for the multiplier
`timescale 1ns/1ps

module fp_mult_tb;

  localparam int WIDTH        = fp_mult_pkg::DEF_WIDTH;
  localparam int FRAC         = fp_mult_pkg::DEF_FRAC;
  localparam bit SIGNED       = fp_mult_pkg::DEF_SIGNED;
  localparam int FIFO_DEPTH   = fp_mult_pkg::DEF_FIFO_DEPTH;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT      = 200 * WIDTH;
  localparam int NUM_RANDOM   = 300;
  localparam int MAX_HELD     = 2 * FIFO_DEPTH + 1;
  localparam int FILL_CYCLES  = 4 * (FIFO_DEPTH + 1) * (WIDTH + 3);

  logic             clk = 1'b0;
  logic             reset;
  logic             req_valid;
  logic             req_ready;
  logic [WIDTH-1:0] req_a;
  logic [WIDTH-1:0] req_b;
  logic             resp_valid;
  logic             resp_ready;
  logic [WIDTH-1:0] resp_c;

  integer seed;
  // 0 always ready, 1 random, 2 held low
  int     ready_mode;
  bit     aborted;
  int     tb_errors;
  int     tests_run;
  int     tests_failed;
  int     chk_reqs;
  int     chk_resps;
  int     chk_errs;

  always #50 clk = ~clk;

  fp_mult_unit #(
    .WIDTH(WIDTH), .FRAC(FRAC), .SIGNED(SIGNED), .FIFO_DEPTH(FIFO_DEPTH)
  ) dut (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
    .req_a(req_a), .req_b(req_b), .resp_valid(resp_valid), .resp_ready(resp_ready),
    .resp_c(resp_c)
  );

  fp_mult_checker #(
    .WIDTH(WIDTH), .FRAC(FRAC), .SIGNED(SIGNED)
  ) chk (
    .clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
    .req_a(req_a), .req_b(req_b), .resp_valid(resp_valid), .resp_ready(resp_ready),
    .resp_c(resp_c), .req_count(chk_reqs), .resp_count(chk_resps), .err_count(chk_errs)
  );

  // ========================================
  // stimulus helpers
  // ========================================

  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
    case (ready_mode)
      0: resp_ready = 1'b1;
      1: resp_ready = 1'($random(seed));
      default: resp_ready = 1'b0;
    endcase
  endtask

  // offer one pair and return after the edge that takes it
  task automatic send_req(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    int waited;
    if (aborted) return;
    req_valid = 1'b1;
    req_a     = a;
    req_b     = b;
    waited    = 0;
    while (!req_ready) begin
      if (waited >= TIMEOUT) begin
        $display("timeout: req_ready stayed low for %0d cycles", TIMEOUT);
        aborted   = 1'b1;
        req_valid = 1'b0;
        return;
      end
      tick();
      waited++;
    end
    tick();
  endtask

  task automatic stop_req();
    req_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (chk_resps != chk_reqs && !aborted) begin
      if (waited >= TIMEOUT) begin
        $display("timeout: %0d responses still missing", chk_reqs - chk_resps);
        aborted = 1'b1;
        return;
      end
      tick();
      waited++;
    end
  endtask

  function automatic int error_total();
    return chk_errs + tb_errors;
  endfunction

  task automatic report(input string name, input int mark);
    tests_run++;
    if (aborted || error_total() != mark) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ========================================
  // tests
  // ========================================

  task automatic run_directed();
    logic [WIDTH-1:0] one;
    logic [WIDTH-1:0] minus_one;
    logic [WIDTH-1:0] most_neg;
    logic [WIDTH-1:0] any;
    one       = WIDTH'(1) << FRAC;
    minus_one = '0 - one;
    most_neg  = {1'b1, {(WIDTH-1){1'b0}}};
    any       = WIDTH'($random(seed));
    send_req(one, one);
    send_req('0, any);
    send_req(any, '0);
    // minus three times two
    send_req(minus_one - one - one, one + one);
    // wraps past the largest positive value
    send_req(most_neg, minus_one);
    stop_req();
    drain();
  endtask

  task automatic run_random(input int count, input bit gaps);
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    int               gap;
    for (int i = 0; i < count && !aborted; i++) begin
      a = WIDTH'($random(seed));
      b = WIDTH'($random(seed));
      send_req(a, b);
      gap = gaps ? ($random(seed) & 3) : 0;
      if (gap != 0) begin
        stop_req();
        repeat (gap) tick();
      end
    end
    stop_req();
    drain();
  endtask

  // resp_ready low until every queue stage is full
  task automatic run_fill();
    int accepted;
    bit took;
    if (aborted) return;
    ready_mode = 2;
    accepted   = 0;
    req_valid  = 1'b1;
    req_a      = WIDTH'($random(seed));
    req_b      = WIDTH'($random(seed));
    for (int cyc = 0; cyc < FILL_CYCLES; cyc++) begin
      took = req_ready;
      tick();
      if (took) begin
        accepted++;
        req_a = WIDTH'($random(seed));
        req_b = WIDTH'($random(seed));
      end
    end
    stop_req();
    if (req_ready !== 1'b0) begin
      $display("[ERROR] req_ready expected 0 got %h", req_ready);
      tb_errors++;
    end
    if (accepted > MAX_HELD) begin
      $display("%0d requests accepted with resp_ready low, limit %0d", accepted, MAX_HELD);
      tb_errors++;
    end
    ready_mode = 0;
    drain();
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d failed, %0d requests, %0d responses, %0d errors",
             tests_run, tests_failed, chk_reqs, chk_resps, error_total());
    if (aborted || tests_failed != 0 || error_total() != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  endtask

  initial begin
    int mark;
    seed       = 32'hd8b9_1d79;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req_a      = '0;
    req_b      = '0;
    resp_ready = 1'b0;
    ready_mode = 0;
    aborted    = 1'b0;
    tb_errors  = 0;
    tests_run  = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) tick();
    reset = 1'b0;
    tick();
    report("reset values", 0);
    mark = error_total();
    run_directed();
    report("directed products", mark);
    mark = error_total();
    run_random(NUM_RANDOM, 1'b0);
    report("random back to back", mark);
    mark = error_total();
    ready_mode = 1;
    run_random(NUM_RANDOM, 1'b1);
    ready_mode = 0;
    report("random back-pressure", mark);
    mark = error_total();
    run_fill();
    report("queue fill and drain", mark);
    mark = error_total();
    run_random(1, 1'b0);
    report("isolated latency", mark);
    finish_run();
  end

endmodule

// ==== vlog.f ====
verilog/fp_mult_pkg.sv
verilog/stream_fifo.sv
verilog/fp_mult_ctrl.sv
verilog/fp_mult_dpath.sv
verilog/fp_mult_unit.sv
dv/fp_mult_checker.sv
dv/fp_mult_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = fp_mult_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
